/* include/jpeg_defs.svh */
// JPEG front end sizes
`ifndef JPEG_DEFS_SVH
`define JPEG_DEFS_SVH

// largest image handled, both must be multiples of 16
`define JPEG_SENSOR_X 64
`define JPEG_SENSOR_Y 32

// bits per sample
`define JPEG_DW 8

// level shift applied to every component
`define JPEG_BIAS 128

// luma store: two stripes of 16 lines, 8 samples per word
`define JPEG_Y_DEPTH (2 * 16 * `JPEG_SENSOR_X / 8)

// chroma store: two stripes of 8 lines at half width
// 8 samples per word
`define JPEG_UV_DEPTH (2 * 8 * `JPEG_SENSOR_X / 16)

`endif

/* hdl/jpeg_pkg.sv */
// JPEG front end types
package jpeg_pkg;

`include "jpeg_defs.svh"

    // one component sample
    typedef logic [`JPEG_DW-1:0] sample_t;

    // eight samples of one block row
    // sample 0 is leftmost and sits in the low byte
    typedef logic [8*`JPEG_DW-1:0] row_t;

    // full 8x8 block, index 0 is the top row
    typedef row_t [7:0] block_t;

    // raster position counters
    typedef logic [$clog2(`JPEG_SENSOR_X)-1:0] xcount_t;
    typedef logic [$clog2(`JPEG_SENSOR_Y)-1:0] ycount_t;

    // component tag carried with each row and block
    typedef enum logic [1:0] {
        Y = 2'd0,
        U = 2'd1,
        V = 2'd2
    } comp_t;

endpackage

/* hdl/dp_ram.sv */
// Byte-masked stripe RAM
`timescale 1ns/1ns

module dp_ram #(
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] wa,
    input  jpeg_pkg::row_t           wd,
    input  logic [7:0]               wbe,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] ra,
    input  logic                     re,
    output jpeg_pkg::row_t           rd
);

    import jpeg_pkg::*;

    // one byte lane per sample
    localparam int BW = $bits(sample_t);

    row_t mem [DEPTH];

    // write port, only enabled lanes change
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 8; i++) begin
                if (wbe[i]) begin
                    mem[wa][i*BW +: BW] <= wd[i*BW +: BW];
                end
            end
        end
    end

    // registered read port
    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        if (re) begin
            rd <= mem[ra];
        end
    end

endmodule

/* hdl/raster_tracker.sv */
// Raster position and 4:2:0 decimation
`timescale 1ns/1ns

module raster_tracker (
    input  logic              clk,
    input  logic              resetn,
    input  logic              sof,
    input  logic              px_valid,
    input  jpeg_pkg::sample_t px_y,
    input  jpeg_pkg::sample_t px_u,
    input  jpeg_pkg::sample_t px_v,
    input  jpeg_pkg::xcount_t x_size_m1,
    input  jpeg_pkg::ycount_t y_size_m1,
    input  logic              buf_hold,
    output logic              in_hold,
    output jpeg_pkg::sample_t s_y,
    output jpeg_pkg::sample_t s_u,
    output jpeg_pkg::sample_t s_v,
    output logic [2:0]        s_valid,
    output jpeg_pkg::xcount_t pix_cnt,
    output jpeg_pkg::ycount_t line_cnt
);

    import jpeg_pkg::*;

    // position of the next expected pixel
    xcount_t x_q;
    ycount_t y_q;
    logic    accept;

    // only full stripe halves push back on the source
    assign in_hold = buf_hold;
    assign accept  = px_valid & ~buf_hold;

    // sof forces the current pixel to the frame origin
    assign pix_cnt  = sof ? '0 : x_q;
    assign line_cnt = sof ? '0 : y_q;

    assign s_y = px_y;
    assign s_u = px_u;
    assign s_v = px_v;

    // luma on every accepted pixel
    // chroma only on even column of even line
    assign s_valid[0] = accept;
    assign s_valid[1] = accept & ~pix_cnt[0] & ~line_cnt[0];
    assign s_valid[2] = accept & ~pix_cnt[0] & ~line_cnt[0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            x_q <= '0;
            y_q <= '0;
        end else if (accept) begin
            if (pix_cnt == x_size_m1) begin
                // wrap to the start of the next line
                x_q <= '0;
                y_q <= line_cnt + 1'b1;
            end else begin
                x_q <= pix_cnt + 1'b1;
                y_q <= line_cnt;
            end
        end
    end

    // no pixel past the last line unless a new frame starts
    a_line_range: assert property (@(posedge clk) disable iff (!resetn)
        accept |-> line_cnt <= y_size_m1)
        else $error("pixel accepted beyond y_size_m1");

    // sof is only meaningful together with a pixel
    a_sof_valid: assert property (@(posedge clk) disable iff (!resetn)
        sof |-> px_valid)
        else $error("sof without px_valid");

endmodule

/* hdl/mcu_buffer.sv */
// Double-buffered MCU stripe store
`timescale 1ns/1ns

`include "jpeg_defs.svh"

module mcu_buffer (
    input  logic              clk,
    input  logic              resetn,
    input  jpeg_pkg::sample_t s_y,
    input  jpeg_pkg::sample_t s_u,
    input  jpeg_pkg::sample_t s_v,
    input  logic [2:0]        s_valid,
    input  jpeg_pkg::xcount_t pix_cnt,
    input  jpeg_pkg::ycount_t line_cnt,
    input  jpeg_pkg::xcount_t x_size_m1,
    input  jpeg_pkg::ycount_t y_size_m1,
    input  logic              row_hold,
    output logic              buf_hold,
    output jpeg_pkg::row_t    row,
    output logic              row_valid,
    output logic [2:0]        row_idx,
    output jpeg_pkg::comp_t   row_comp
);

    import jpeg_pkg::*;

    // position counter width and macroblock column count width
    localparam int XW  = $bits(xcount_t);
    localparam int HW  = XW - 4;
    localparam int YAW = $clog2(`JPEG_Y_DEPTH);
    localparam int CAW = $clog2(`JPEG_UV_DEPTH);

    // two-entry stripe FIFO, bit 0 picks the RAM half
    logic [1:0] wptr;
    logic [1:0] rptr;
    logic       full;
    logic       empty;

    // read sequencer: row in block, block in MCU, macroblock column
    logic [2:0]    row_cnt;
    logic [2:0]    mcu_cnt;
    logic [HW-1:0] blk_h;
    logic          last_blk_h;
    logic          rd_go;
    comp_t         rsel;

    // level-shifted samples
    sample_t y_lvl;
    sample_t u_lvl;
    sample_t v_lvl;

    logic [YAW-1:0] y_wa;
    logic [YAW-1:0] y_ra;
    logic [CAW-1:0] c_wa;
    logic [CAW-1:0] c_ra;
    logic [7:0]     y_wbe;
    logic [7:0]     c_wbe;
    logic           stripe_done;

    row_t y_rd;
    row_t u_rd;
    row_t v_rd;

    assign empty    = wptr == rptr;
    assign full     = (wptr[1] != rptr[1]) & (wptr[0] == rptr[0]);
    assign buf_hold = full;

    // last pixel of a 16-line stripe or of the frame
    assign stripe_done = s_valid[0] & (pix_cnt == x_size_m1) &
                         ((line_cnt[3:0] == 4'd15) | (line_cnt == y_size_m1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= '0;
        end else if (stripe_done) begin
            wptr <= wptr + 1'b1;
        end
    end

    // JPEG level shift
    assign y_lvl = s_y - sample_t'(`JPEG_BIAS);
    assign u_lvl = s_u - sample_t'(`JPEG_BIAS);
    assign v_lvl = s_v - sample_t'(`JPEG_BIAS);

    // luma word: half, line in stripe, 8-pixel group
    assign y_wa  = {wptr[0], line_cnt[3:0], pix_cnt[XW-1:3]};
    assign y_wbe = 8'b1 << pix_cnt[2:0];

    // chroma is half size both ways
    assign c_wa  = {wptr[0], line_cnt[3:1], pix_cnt[XW-1:4]};
    assign c_wbe = 8'b1 << pix_cnt[3:1];

    // read side advances one row per cycle unless held
    assign rd_go      = ~row_hold & ~empty;
    assign last_blk_h = blk_h == x_size_m1[XW-1:4];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr <= '0;
        end else if (rd_go & (row_cnt == 3'd7) & (mcu_cnt == 3'd5) & last_blk_h) begin
            // whole stripe read, free its half
            rptr <= rptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            row_cnt <= '0;
            mcu_cnt <= '0;
            blk_h   <= '0;
        end else if (rd_go) begin
            row_cnt <= row_cnt + 1'b1;
            if (row_cnt == 3'd7) begin
                if (mcu_cnt == 3'd5) begin
                    mcu_cnt <= '0;
                    if (last_blk_h) begin
                        blk_h <= '0;
                    end else begin
                        blk_h <= blk_h + 1'b1;
                    end
                end else begin
                    mcu_cnt <= mcu_cnt + 1'b1;
                end
            end
        end
    end

    // MCU 0..3 luma, 4 is U, 5 is V
    always_comb begin
        if (mcu_cnt < 3'd4) begin
            rsel = Y;
        end else if (mcu_cnt == 3'd4) begin
            rsel = U;
        end else begin
            rsel = V;
        end
    end

    // luma: mcu bit 1 picks upper or lower 8 lines
    // mcu bit 0 picks left or right 8 columns
    assign y_ra = {rptr[0], mcu_cnt[1], row_cnt, blk_h, mcu_cnt[0]};
    assign c_ra = {rptr[0], row_cnt, blk_h};

    dp_ram #(
        .DEPTH (`JPEG_Y_DEPTH)
    ) y_ram (
        .clk (clk),
        .wa  (y_wa),
        .wd  ({8{y_lvl}}),
        .wbe (y_wbe),
        .we  (s_valid[0]),
        .ra  (y_ra),
        .re  (rd_go & (rsel == Y)),
        .rd  (y_rd)
    );

    dp_ram #(
        .DEPTH (`JPEG_UV_DEPTH)
    ) u_ram (
        .clk (clk),
        .wa  (c_wa),
        .wd  ({8{u_lvl}}),
        .wbe (c_wbe),
        .we  (s_valid[1]),
        .ra  (c_ra),
        .re  (rd_go & (rsel == U)),
        .rd  (u_rd)
    );

    dp_ram #(
        .DEPTH (`JPEG_UV_DEPTH)
    ) v_ram (
        .clk (clk),
        .wa  (c_wa),
        .wd  ({8{v_lvl}}),
        .wbe (c_wbe),
        .we  (s_valid[2]),
        .ra  (c_ra),
        .re  (rd_go & (rsel == V)),
        .rd  (v_rd)
    );

    // valid lines up with the registered RAM read
    always_ff @(posedge clk) begin
        if (!resetn) begin
            row_valid <= 1'b0;
        end else if (!row_hold) begin
            row_valid <= ~empty;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            row_comp <= rsel;
            row_idx  <= row_cnt;
        end
    end

    // output mux follows the tag of the row in flight
    always_comb begin
        case (row_comp)
            Y:       row = y_rd;
            U:       row = u_rd;
            default: row = v_rd;
        endcase
    end

    // image size must be whole macroblocks
    a_size_x: assert property (@(posedge clk) disable iff (!resetn)
        &x_size_m1[3:0])
        else $error("x_size_m1 not a multiple of 16 minus 1");

    a_size_y: assert property (@(posedge clk) disable iff (!resetn)
        &y_size_m1[3:0])
        else $error("y_size_m1 not a multiple of 16 minus 1");

    // tracker must stop writes once both halves are full
    a_no_write_full: assert property (@(posedge clk) disable iff (!resetn)
        |s_valid |-> !buf_hold)
        else $error("stripe write while buffer full");

endmodule

/* hdl/block_collector.sv */
// 8x8 block assembly
`timescale 1ns/1ns

module block_collector (
    input  logic              clk,
    input  logic              resetn,
    input  jpeg_pkg::row_t    row,
    input  logic              row_valid,
    input  logic [2:0]        row_idx,
    input  jpeg_pkg::comp_t   row_comp,
    input  logic              blk_hold,
    output logic              row_hold,
    output jpeg_pkg::block_t  blk,
    output jpeg_pkg::comp_t   blk_comp,
    output logic              blk_valid
);

    import jpeg_pkg::*;

    logic       row_take;
    // next row index expected and tag of the block being filled
    logic [2:0] exp_idx;
    comp_t      fill_comp;

    // single slot, stall rows while a finished block waits
    assign row_hold = blk_valid & blk_hold;
    assign row_take = row_valid & ~row_hold;

    always_ff @(posedge clk) begin
        if (row_take) begin
            blk[row_idx] <= row;
            if (row_idx == 3'd7) begin
                blk_comp <= row_comp;
            end
        end
    end

    // full after row 7, cleared once taken
    always_ff @(posedge clk) begin
        if (!resetn) begin
            blk_valid <= 1'b0;
        end else if (row_take & (row_idx == 3'd7)) begin
            blk_valid <= 1'b1;
        end else if (!blk_hold) begin
            blk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exp_idx <= '0;
        end else if (row_take) begin
            exp_idx <= row_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (row_take & (row_idx == 3'd0)) begin
            fill_comp <= row_comp;
        end
    end

    // rows come in order and a block never mixes components
    a_row_order: assert property (@(posedge clk) disable iff (!resetn)
        row_take |-> row_idx == exp_idx)
        else $error("row index out of order");

    a_row_comp: assert property (@(posedge clk) disable iff (!resetn)
        row_take && row_idx != 3'd0 |-> row_comp == fill_comp)
        else $error("component changed inside a block");

endmodule

/* hdl/jpeg_mcu_front.sv */
// JPEG MCU front end top
`timescale 1ns/1ns

module jpeg_mcu_front (
    input  logic              clk,
    input  logic              resetn,
    input  logic              sof,
    input  logic              px_valid,
    input  jpeg_pkg::sample_t px_y,
    input  jpeg_pkg::sample_t px_u,
    input  jpeg_pkg::sample_t px_v,
    input  jpeg_pkg::xcount_t x_size_m1,
    input  jpeg_pkg::ycount_t y_size_m1,
    input  logic              blk_hold,
    output logic              in_hold,
    output jpeg_pkg::block_t  blk,
    output jpeg_pkg::comp_t   blk_comp,
    output logic              blk_valid
);

    import jpeg_pkg::*;

    // tracker to stripe store
    sample_t    s_y;
    sample_t    s_u;
    sample_t    s_v;
    logic [2:0] s_valid;
    xcount_t    pix_cnt;
    ycount_t    line_cnt;
    logic       buf_hold;

    // stripe store to collector
    row_t       row;
    logic       row_valid;
    logic [2:0] row_idx;
    comp_t      row_comp;
    logic       row_hold;

    raster_tracker i_tracker (
        .clk       (clk),
        .resetn    (resetn),
        .sof       (sof),
        .px_valid  (px_valid),
        .px_y      (px_y),
        .px_u      (px_u),
        .px_v      (px_v),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .buf_hold  (buf_hold),
        .in_hold   (in_hold),
        .s_y       (s_y),
        .s_u       (s_u),
        .s_v       (s_v),
        .s_valid   (s_valid),
        .pix_cnt   (pix_cnt),
        .line_cnt  (line_cnt)
    );

    mcu_buffer i_buffer (
        .clk       (clk),
        .resetn    (resetn),
        .s_y       (s_y),
        .s_u       (s_u),
        .s_v       (s_v),
        .s_valid   (s_valid),
        .pix_cnt   (pix_cnt),
        .line_cnt  (line_cnt),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .row_hold  (row_hold),
        .buf_hold  (buf_hold),
        .row       (row),
        .row_valid (row_valid),
        .row_idx   (row_idx),
        .row_comp  (row_comp)
    );

    block_collector i_collector (
        .clk       (clk),
        .resetn    (resetn),
        .row       (row),
        .row_valid (row_valid),
        .row_idx   (row_idx),
        .row_comp  (row_comp),
        .blk_hold  (blk_hold),
        .row_hold  (row_hold),
        .blk       (blk),
        .blk_comp  (blk_comp),
        .blk_valid (blk_valid)
    );

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held low for the first four rising edges
    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

/* testbench/tb_jpeg_mcu_front.sv */
// JPEG MCU front end testbench
`timescale 1ns/1ns

`include "jpeg_defs.svh"

module tb_jpeg_mcu_front;

    import jpeg_pkg::*;

    // cycle budgets for one pixel handshake and for draining all blocks
    localparam int ACCEPT_LIMIT = 20000;
    localparam int DRAIN_LIMIT  = 100000;

    logic    clk;
    logic    resetn;
    logic    sof;
    logic    px_valid;
    sample_t px_y;
    sample_t px_u;
    sample_t px_v;
    xcount_t x_size_m1;
    ycount_t y_size_m1;
    logic    blk_hold;
    logic    in_hold;
    block_t  blk;
    comp_t   blk_comp;
    logic    blk_valid;

    // current frame as sent
    sample_t fr_y [`JPEG_SENSOR_Y][`JPEG_SENSOR_X];
    sample_t fr_u [`JPEG_SENSOR_Y][`JPEG_SENSOR_X];
    sample_t fr_v [`JPEG_SENSOR_Y][`JPEG_SENSOR_X];

    // reference blocks in delivery order
    block_t exp_blk [$];
    comp_t  exp_comp [$];

    // separate streams for pixels and for blk_hold
    logic [15:0] px_lfsr;
    logic [15:0] hold_lfsr;
    int          hold_mode;

    int err_cnt;
    int check_cnt;
    int blk_cnt;
    int test_cnt;
    int test_fail;
    bit aborted;
    bit hold_seen;

    tb_clock_gen i_clock (
        .clk    (clk),
        .resetn (resetn)
    );

    jpeg_mcu_front i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .sof       (sof),
        .px_valid  (px_valid),
        .px_y      (px_y),
        .px_u      (px_u),
        .px_v      (px_v),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .blk_hold  (blk_hold),
        .in_hold   (in_hold),
        .blk       (blk),
        .blk_comp  (blk_comp),
        .blk_valid (blk_valid)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit, msb first
    function automatic logic [7:0] take_bits(inout logic [15:0] state, input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            r = {r[6:0], state[0]};
        end
        return r;
    endfunction

    task automatic compare_block(input block_t got, input block_t exp);
        bit bad;
        bad = 1'b0;
        check_cnt++;
        for (int r = 0; r < 8; r++) begin
            if (got[r] !== exp[r]) begin
                $display("FAILED blk[%0d]: got %h expected %h", r, got[r], exp[r]);
                bad = 1'b1;
            end
        end
        if (bad) begin
            err_cnt++;
        end
    endtask

    task automatic compare_comp(input comp_t got, input comp_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAILED blk_comp: got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    // a block is taken on the edge after blk_valid high with blk_hold low
    initial begin : block_monitor
        forever begin
            @(negedge clk);
            if (resetn && blk_valid && !blk_hold) begin
                if (exp_blk.size() == 0) begin
                    $display("an extra block was delivered with tag %0d", blk_comp);
                    err_cnt++;
                end else begin
                    compare_block(blk, exp_blk.pop_front());
                    compare_comp(blk_comp, exp_comp.pop_front());
                end
                blk_cnt++;
            end
        end
    end

    // mode 0 never holds, 1 holds at random, 2 holds for long stretches
    initial begin : hold_driver
        int hold_left;
        hold_left = 0;
        hold_lfsr = 16'd23;
        blk_hold  = 1'b0;
        forever begin
            @(posedge clk);
            if (hold_mode == 1) begin
                blk_hold <= take_bits(hold_lfsr, 1) == 8'd1;
            end else if (hold_mode == 2) begin
                if (hold_left > 0) begin
                    blk_hold <= 1'b1;
                    hold_left--;
                end else begin
                    // one free cycle, then 64..319 held
                    blk_hold  <= 1'b0;
                    hold_left = 64 + int'(take_bits(hold_lfsr, 8));
                end
            end else begin
                blk_hold <= 1'b0;
            end
        end
    end

    // odd column or odd line chroma gets extreme values when asked
    task automatic make_frame(input int w, input int h, input bit odd_ext);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                fr_y[y][x] = take_bits(px_lfsr, 8);
                fr_u[y][x] = take_bits(px_lfsr, 8);
                fr_v[y][x] = take_bits(px_lfsr, 8);
                if (odd_ext && ((x % 2) == 1 || (y % 2) == 1)) begin
                    fr_u[y][x] = 8'hff;
                    fr_v[y][x] = 8'h00;
                end
            end
        end
    endtask

    // stripe, macroblock, then Y0 Y1 Y2 Y3 U V, all level shifted
    task automatic expand_frame(input int w, input int h);
        block_t  b;
        sample_t s;
        for (int st = 0; st < h / 16; st++) begin
            for (int mb = 0; mb < w / 16; mb++) begin
                for (int m = 0; m < 6; m++) begin
                    for (int r = 0; r < 8; r++) begin
                        for (int c = 0; c < 8; c++) begin
                            if (m < 4) begin
                                s = fr_y[16 * st + 8 * (m / 2) + r][16 * mb + 8 * (m % 2) + c];
                            end else if (m == 4) begin
                                s = fr_u[2 * (8 * st + r)][2 * (8 * mb + c)];
                            end else begin
                                s = fr_v[2 * (8 * st + r)][2 * (8 * mb + c)];
                            end
                            b[r][8 * c +: 8] = s - 8'd128;
                        end
                    end
                    exp_blk.push_back(b);
                    exp_comp.push_back(m < 4 ? Y : (m == 4 ? U : V));
                end
            end
        end
    endtask

    // pixel stays on the bus until a falling edge sees in_hold low
    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (in_hold) begin
            hold_seen = 1'b1;
            if (n == ACCEPT_LIMIT) begin
                $display("timeout: pixel never accepted while in_hold stayed high");
                err_cnt++;
                aborted = 1'b1;
                return;
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic send_frame(input int w, input int h, input bit gaps);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                if (aborted) begin
                    return;
                end
                // idle cycles before this pixel
                while (gaps && take_bits(px_lfsr, 2) == 8'd0) begin
                    @(posedge clk);
                    px_valid <= 1'b0;
                    sof      <= 1'b0;
                end
                @(posedge clk);
                sof      <= (x == 0 && y == 0);
                px_valid <= 1'b1;
                px_y     <= fr_y[y][x];
                px_u     <= fr_u[y][x];
                px_v     <= fr_v[y][x];
                wait_accept();
            end
        end
    endtask

    // all expected blocks out, then a quiet spell to catch extras
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_blk.size() != 0) begin
            if (n == DRAIN_LIMIT) begin
                $display("timeout: %0d blocks were never delivered", exp_blk.size());
                err_cnt++;
                aborted = 1'b1;
                return;
            end
            n++;
            @(negedge clk);
        end
        repeat (16) @(negedge clk);
    endtask

    task automatic run_test(input int num, input string name, input int w, input int h,
                            input int frames, input bit gaps, input int hmode,
                            input bit odd_ext);
        int err0;
        int blk0;
        int expected;
        if (aborted) begin
            return;
        end
        err0      = err_cnt;
        blk0      = blk_cnt;
        hold_seen = 1'b0;
        expected  = frames * (w / 16) * (h / 16) * 6;
        @(posedge clk);
        x_size_m1 <= xcount_t'(w - 1);
        y_size_m1 <= ycount_t'(h - 1);
        hold_mode <= hmode;
        // frames go out back to back with no idle between them
        for (int f = 0; f < frames; f++) begin
            make_frame(w, h, odd_ext);
            expand_frame(w, h);
            send_frame(w, h, gaps);
        end
        @(posedge clk);
        px_valid <= 1'b0;
        sof      <= 1'b0;
        wait_drain();
        if (!aborted && blk_cnt - blk0 != expected) begin
            $display("wrong number of blocks, %0d seen and %0d expected",
                     blk_cnt - blk0, expected);
            err_cnt++;
        end
        if (!aborted && hmode == 2 && !hold_seen) begin
            $display("in_hold never stalled the pixel source");
            err_cnt++;
        end
        test_cnt++;
        if (err_cnt != err0) begin
            test_fail++;
        end
        $display("test %0d %s: %s, %0d blocks, %0d errors", num, name,
                 (err_cnt == err0) ? "pass" : "fail", blk_cnt - blk0, err_cnt - err0);
    endtask

    initial begin : main_flow
        int n;
        sof       = 1'b0;
        px_valid  = 1'b0;
        px_y      = '0;
        px_u      = '0;
        px_v      = '0;
        x_size_m1 = xcount_t'(15);
        y_size_m1 = ycount_t'(15);
        px_lfsr   = 16'd23;
        hold_mode = 0;
        err_cnt   = 0;
        check_cnt = 0;
        blk_cnt   = 0;
        test_cnt  = 0;
        test_fail = 0;
        aborted   = 1'b0;
        n         = 0;
        @(posedge clk);
        while (!resetn && !aborted) begin
            if (n == 100) begin
                $display("timeout: reset was never released");
                err_cnt++;
                aborted = 1'b1;
            end
            n++;
            @(posedge clk);
        end

        run_test(1, "single 16x16 frame", 16, 16, 1, 1'b0, 0, 1'b0);
        run_test(2, "64x32 stripe handover", 64, 32, 1, 1'b0, 0, 1'b0);
        run_test(3, "gaps and two frames", 32, 32, 2, 1'b1, 1, 1'b0);
        run_test(4, "long block holds", 64, 32, 2, 1'b0, 2, 1'b0);
        run_test(5, "chroma decimation", 32, 16, 1, 1'b1, 1, 1'b1);

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 test_cnt, test_fail, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
hdl/jpeg_pkg.sv
hdl/dp_ram.sv
hdl/raster_tracker.sv
hdl/mcu_buffer.sv
hdl/block_collector.sv
hdl/jpeg_mcu_front.sv
testbench/tb_clock_gen.sv
testbench/tb_jpeg_mcu_front.sv
